//--- Bender.yml
package:
  name: pipe_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/pipe_ctrl_pkg.sv
      - source/mem_pkg.sv
      - source/mem_arbiter.sv
      - source/shared_ram.sv
      - source/fetch_align.sv
      - source/pipeline_control.sv
      - source/pipe_ctrl_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/pipe_ctrl_tb.sv

//--- bench/pipe_ctrl_cases.txt
# HAZ next load_use jump muldiv trap_stall trap_flush exp_stall exp_flush
# WR/RD/MEMSTALL addr data, FETCH addr count instr0 instr1, CONTEND faddr instr daddr data
HAZ 0 0 0 0 0 0 00 00
HAZ 0 1 0 0 0 0 03 04
HAZ 0 0 0 1 0 0 07 08
HAZ 0 1 0 1 0 0 07 08
HAZ 0 0 1 0 0 0 02 06
HAZ 0 1 1 1 0 0 02 06
HAZ 0 0 0 0 1 0 3f 0e
HAZ 0 1 1 1 1 0 3f 0e
HAZ 0 0 0 0 0 1 02 0e
HAZ 0 0 0 0 1 1 02 0e
HAZ 0 1 1 1 1 1 02 0e
HAZ 1 0 0 0 0 0 0f 00
HAZ 1 1 1 1 1 1 0f 00
WR 10 cafe0001
RD 10 cafe0001
WR 11 12345678
WR ff a5a55a5a
RD 11 12345678
RD ff a5a55a5a
WR 20 00000013
WR 21 45054501
WR 22 8082c422
WR 24 00134501
WR 25 fe010113
FETCH 20 1 00000013 00000000
FETCH 21 2 00004501 00004505
FETCH 22 2 0000c422 00008082
FETCH 24 1 00004501 00000000
FETCH 25 1 fe010113 00000000
MEMSTALL ff a5a55a5a
CONTEND 25 fe010113 11 12345678
CONTEND 20 00000013 10 cafe0001

//--- bench/pipe_ctrl_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_params.svh"

module pipe_ctrl_tb;

  localparam int TMO = 20;                       // max cycles for any single wait

  // expected masks, bit 0 is PC and bit 5 is MEM_WB
  localparam pipe_ctrl_pkg::stage_vec_t RST_FLUSH_EXP = 6'b011111;
  localparam pipe_ctrl_pkg::stage_vec_t MEM_STALL_EXP = 6'b001111; // fetch wait reuses it
  localparam pipe_ctrl_pkg::stage_vec_t MEM_FLUSH_EXP = 6'b010000;
  localparam pipe_ctrl_pkg::stage_vec_t CMP_MASK_EXP  = 6'b000010; // compress stall and flush

  logic                      clk, rst;
  logic                      fetch_req_i, data_req_i, data_we_i;
  logic [`RAM_AW-1:0]        fetch_addr_i, data_addr_i;
  logic [`XLEN-1:0]          data_wdata_i;
  logic                      next_stall_preif_i, load_use_i, jump_i, muldiv_i;
  logic                      trap_stall_i, trap_flush_i;
  logic                      instr_valid_o, data_valid_o;
  logic [`XLEN-1:0]          instr_o, data_rdata_o;
  pipe_ctrl_pkg::stage_vec_t stall_o, flush_o;
  integer                    seed;

  pipe_ctrl_top dut0 (
    .clk, .rst,
    .fetch_req_i, .fetch_addr_i,
    .data_req_i, .data_we_i, .data_addr_i, .data_wdata_i,
    .next_stall_preif_i, .load_use_i, .jump_i, .muldiv_i,
    .trap_stall_i, .trap_flush_i,
    .instr_valid_o, .instr_o, .data_valid_o, .data_rdata_o,
    .stall_o, .flush_o
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                      // 100 ns period
  end

  // ====================
  // checks
  // ====================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_stage_vec(input string name, input pipe_ctrl_pkg::stage_vec_t got,
                                 input pipe_ctrl_pkg::stage_vec_t exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %0t %s: got %b, expected %b", $time, name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %0t %s: got %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_instr(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %0t %s: got %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    if (got != exp)
      abort_run($sformatf("FAIL %0t %s: got %0d, expected %0d", $time, name, got, exp));
  endtask

  // ====================
  // drivers
  // ====================
  task automatic drive_idle();
    logic [31:0] rnd;
    rnd = $random(seed);
    fetch_req_i  <= 1'b0;
    data_req_i   <= 1'b0;
    data_we_i    <= 1'b0;
    fetch_addr_i <= rnd[`RAM_AW-1:0];            // idle payload is noise
    data_addr_i  <= rnd[2*`RAM_AW-1:`RAM_AW];
    data_wdata_i <= $random(seed);
  endtask

  task automatic clear_hazards();
    next_stall_preif_i <= 1'b0;
    load_use_i         <= 1'b0;
    jump_i             <= 1'b0;
    muldiv_i           <= 1'b0;
    trap_stall_i       <= 1'b0;
    trap_flush_i       <= 1'b0;
  endtask

  // drive on the rising edge, come back at the falling edge to sample
  task automatic next_cycle();
    @(posedge clk);
    drive_idle();
    @(negedge clk);
  endtask

  task automatic issue_req(input logic f_en, input logic [`RAM_AW-1:0] f_addr,
                           input logic d_en, input logic d_we,
                           input logic [`RAM_AW-1:0] d_addr, input logic [`XLEN-1:0] d_wdata);
    @(posedge clk);
    fetch_req_i  <= f_en;
    fetch_addr_i <= f_addr;
    data_req_i   <= d_en;
    data_we_i    <= d_we;
    data_addr_i  <= d_addr;
    data_wdata_i <= d_wdata;
    @(negedge clk);
  endtask

  task automatic wait_data(output int lat);
    lat = 0;
    while (data_valid_o !== 1'b1) begin
      next_cycle();
      lat++;
      if (lat > TMO) abort_run("timeout: data_valid_o never came back from the RAM");
    end
  endtask

  task automatic wait_instr(output int lat);
    lat = 0;
    while (instr_valid_o !== 1'b1) begin
      next_cycle();
      lat++;
      if (lat > TMO) abort_run("timeout: instr_valid_o never came after a fetch");
    end
  endtask

  // ====================
  // case runners
  // ====================
  task automatic apply_hazards(input logic nxt, lu, jmp, md, ts, tf,
                               input pipe_ctrl_pkg::stage_vec_t exp_stall, exp_flush);
    @(posedge clk);
    drive_idle();
    next_stall_preif_i <= nxt;
    load_use_i         <= lu;
    jump_i             <= jmp;
    muldiv_i           <= md;
    trap_stall_i       <= ts;
    trap_flush_i       <= tf;
    @(negedge clk);
    check_stage_vec("stall_o", stall_o, exp_stall); // same cycle, combinational
    check_stage_vec("flush_o", flush_o, exp_flush);
    @(posedge clk);
    drive_idle();
    clear_hazards();
    @(negedge clk);
  endtask

  task automatic write_word(input logic [`RAM_AW-1:0] addr, input logic [`XLEN-1:0] data);
    int lat;
    issue_req(1'b0, '0, 1'b1, 1'b1, addr, data);
    check_stage_vec("stall_o", stall_o, MEM_STALL_EXP);
    check_stage_vec("flush_o", flush_o, MEM_FLUSH_EXP);
    wait_data(lat);
    check_latency("write latency", lat, `RAM_LAT);
    next_cycle();
  endtask

  task automatic read_word(input logic [`RAM_AW-1:0] addr, input logic [`XLEN-1:0] exp);
    int lat;
    issue_req(1'b0, '0, 1'b1, 1'b0, addr, '0);
    wait_data(lat);
    check_latency("read latency", lat, `RAM_LAT);
    check_word("data_rdata_o", data_rdata_o, exp);
    next_cycle();
  endtask

  task automatic fetch_word(input logic [`RAM_AW-1:0] addr, input int n,
                            input logic [`XLEN-1:0] i0, i1);
    int lat;
    issue_req(1'b1, addr, 1'b0, 1'b0, '0, '0);
    check_stage_vec("stall_o", stall_o, MEM_STALL_EXP); // fetch wait
    check_stage_vec("flush_o", flush_o, '0);
    wait_instr(lat);
    check_latency("fetch latency", lat, `RAM_LAT);
    check_instr("instr_o", instr_o, i0);
    next_cycle();
    if (n == 2) begin
      if (instr_valid_o !== 1'b1)
        abort_run("the high compressed half did not follow the low half");
      check_instr("instr_o", instr_o, i1);
      check_stage_vec("stall_o", stall_o, CMP_MASK_EXP);
      check_stage_vec("flush_o", flush_o, CMP_MASK_EXP);
      next_cycle();
    end
    if (instr_valid_o !== 1'b0) abort_run("an extra instruction strobe followed the fetch");
  endtask

  task automatic mem_stall_release(input logic [`RAM_AW-1:0] addr, input logic [`XLEN-1:0] exp);
    int lat;
    @(posedge clk);
    drive_idle();
    next_stall_preif_i <= 1'b1;
    @(negedge clk);
    check_stage_vec("stall_o", stall_o, MEM_STALL_EXP); // next-stall alone
    check_stage_vec("flush_o", flush_o, '0);
    issue_req(1'b0, '0, 1'b1, 1'b0, addr, '0);
    check_stage_vec("stall_o", stall_o, MEM_STALL_EXP);
    check_stage_vec("flush_o", flush_o, MEM_FLUSH_EXP);
    lat = 0;
    while (data_valid_o !== 1'b1) begin
      next_cycle();
      lat++;
      if (lat > TMO) abort_run("timeout: data_valid_o never came during the memory stall");
      check_stage_vec("stall_o", stall_o, MEM_STALL_EXP); // held through the done cycle
      check_stage_vec("flush_o", flush_o, MEM_FLUSH_EXP);
    end
    check_latency("read latency", lat, `RAM_LAT);
    check_word("data_rdata_o", data_rdata_o, exp);
    next_cycle();
    check_stage_vec("stall_o", stall_o, '0);     // force-advance cycle
    check_stage_vec("flush_o", flush_o, '0);
    next_cycle();
    check_stage_vec("stall_o", stall_o, MEM_STALL_EXP);
    check_stage_vec("flush_o", flush_o, '0);
    @(posedge clk);
    drive_idle();
    clear_hazards();
    @(negedge clk);
  endtask

  task automatic contend_fetch_data(input logic [`RAM_AW-1:0] faddr,
                                    input logic [`XLEN-1:0] instr_exp,
                                    input logic [`RAM_AW-1:0] daddr,
                                    input logic [`XLEN-1:0] data_exp);
    int cyc, d_cyc, i_cyc;
    issue_req(1'b1, faddr, 1'b1, 1'b0, daddr, '0);
    cyc   = 0;
    d_cyc = -1;
    i_cyc = -1;
    while (d_cyc < 0 || i_cyc < 0) begin
      if (cyc > TMO)
        abort_run($sformatf("timeout: %s never came under contention",
                            d_cyc < 0 ? "data_valid_o" : "instr_valid_o"));
      if (data_valid_o === 1'b1) begin
        d_cyc = cyc;
        check_word("data_rdata_o", data_rdata_o, data_exp);
      end
      if (instr_valid_o === 1'b1) begin
        i_cyc = cyc;
        check_instr("instr_o", instr_o, instr_exp);
      end
      next_cycle();
      cyc++;
    end
    check_latency("data latency under contention", d_cyc, `RAM_LAT);
    if (i_cyc <= d_cyc) abort_run("the fetch finished before the data read it competed with");
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    integer           fd;
    integer           n_ok;
    int               n_cases;
    logic [8*12-1:0]  op;
    logic [8*160-1:0] line;
    logic [31:0]      a0, a1, a2, a3, a4, a5, a6, a7;
    seed               = 32'h996f;
    rst                = 1'b1;
    fetch_req_i        = 1'b0;
    fetch_addr_i       = '0;
    data_req_i         = 1'b0;
    data_we_i          = 1'b0;
    data_addr_i        = '0;
    data_wdata_i       = '0;
    next_stall_preif_i = 1'b0;
    load_use_i         = 1'b0;
    jump_i             = 1'b0;
    muldiv_i           = 1'b0;
    trap_stall_i       = 1'b0;
    trap_flush_i       = 1'b0;
    repeat (16) begin
      @(negedge clk);
      check_stage_vec("stall_o", stall_o, '0);
      check_stage_vec("flush_o", flush_o, RST_FLUSH_EXP);
      if (instr_valid_o !== 1'b0 || data_valid_o !== 1'b0)
        abort_run("a valid strobe was high during reset");
    end
    @(posedge clk);
    rst <= 1'b0;
    drive_idle();
    @(negedge clk);
    check_stage_vec("stall_o", stall_o, '0);     // first cycle out of reset
    check_stage_vec("flush_o", flush_o, RST_FLUSH_EXP);
    if (instr_valid_o !== 1'b0 || data_valid_o !== 1'b0)
      abort_run("a valid strobe was high in the first cycle after reset");
    next_cycle();
    check_stage_vec("flush_o", flush_o, '0);
    fd = $fopen("bench/pipe_ctrl_cases.txt", "r");
    if (fd == 0) abort_run("cannot open bench/pipe_ctrl_cases.txt");
    n_cases = 0;
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        n_ok = $fgets(line, fd);                 // rest of a comment line
      end else if (op == "HAZ") begin
        n_ok = $fscanf(fd, "%h %h %h %h %h %h %h %h", a0, a1, a2, a3, a4, a5, a6, a7);
        if (n_ok != 8) abort_run("malformed HAZ line in the case file");
        apply_hazards(a0[0], a1[0], a2[0], a3[0], a4[0], a5[0],
                      a6[`PIPE_STAGES-1:0], a7[`PIPE_STAGES-1:0]);
      end else if (op == "WR" || op == "RD" || op == "MEMSTALL") begin
        n_ok = $fscanf(fd, "%h %h", a0, a1);
        if (n_ok != 2) abort_run("malformed WR, RD or MEMSTALL line in the case file");
        if (op == "WR") write_word(a0[`RAM_AW-1:0], a1);
        else if (op == "RD") read_word(a0[`RAM_AW-1:0], a1);
        else mem_stall_release(a0[`RAM_AW-1:0], a1);
      end else if (op == "FETCH") begin
        n_ok = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
        if (n_ok != 4) abort_run("malformed FETCH line in the case file");
        fetch_word(a0[`RAM_AW-1:0], a1, a2, a3);
      end else if (op == "CONTEND") begin
        n_ok = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
        if (n_ok != 4) abort_run("malformed CONTEND line in the case file");
        contend_fetch_data(a0[`RAM_AW-1:0], a1, a2[`RAM_AW-1:0], a3);
      end else begin
        abort_run($sformatf("unknown opcode %0s in the case file", op));
      end
      if (op != "#") n_cases++;
    end
    $fclose(fd);
    if (n_cases > 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      abort_run("the case file held no cases");
    end
  end

endmodule

`default_nettype wire

//--- include/pipe_params.svh
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// ====================
// core-wide sizes
// ====================
`define PIPE_STAGES 6   // one bit per stage in stall/flush
`define XLEN        32  // data and instruction word
`define RAM_AW      8   // ram word address
`define RAM_LAT     2   // start to done, in cycles

`endif

//--- sim.f
+incdir+include
source/pipe_ctrl_pkg.sv
source/mem_pkg.sv
source/mem_arbiter.sv
source/shared_ram.sv
source/fetch_align.sv
source/pipeline_control.sv
source/pipe_ctrl_top.sv
bench/pipe_ctrl_tb.sv

//--- source/fetch_align.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_params.svh"

module fetch_align (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 word_valid_i,
  input  wire [`XLEN-1:0]     word_i,
  output logic                instr_valid_o,
  output logic [`XLEN-1:0]    instr_o,
  output logic                compress_stall_o
);

  mem_pkg::instr_word_u word_u;
  logic                 lo_c, hi_c;
  logic                 hold_q;                  // high parcel waiting
  logic [`XLEN/2-1:0]   hold_half_q;

  assign word_u.full = word_i;
  assign lo_c = mem_pkg::is_compressed(word_u.half[0]);
  assign hi_c = mem_pkg::is_compressed(word_u.half[1]);

  // ====================
  // output select
  // ====================
  always_comb begin
    if (hold_q) begin
      instr_o = {{(`XLEN/2){1'b0}}, hold_half_q}; // second parcel, one cycle late
    end else if (lo_c) begin
      instr_o = {{(`XLEN/2){1'b0}}, word_u.half[0]};
    end else begin
      instr_o = word_u.full;                      // plain 32-bit instr
    end
  end

  assign instr_valid_o    = hold_q | word_valid_i;
  assign compress_stall_o = hold_q;              // pre_if waits for the high half

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= word_valid_i & lo_c & hi_c;       // both parcels rvc
    end
  end

  always_ff @(posedge clk) begin
    if (word_valid_i) hold_half_q <= word_u.half[1];
  end

endmodule

`default_nettype wire

//--- source/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_params.svh"

module mem_arbiter (
  input  wire                 clk,
  input  wire                 rst,
  // fetch port
  input  wire                 fetch_req_i,
  input  wire [`RAM_AW-1:0]   fetch_addr_i,
  // data port
  input  wire                 data_req_i,
  input  wire                 data_we_i,
  input  wire [`RAM_AW-1:0]   data_addr_i,
  input  wire [`XLEN-1:0]     data_wdata_i,
  // ram side
  input  wire                 ram_done_i,
  input  wire [`XLEN-1:0]     ram_rdata_i,
  output logic                ram_start_o,
  output logic                ram_we_o,
  output logic [`RAM_AW-1:0]  ram_addr_o,
  output logic [`XLEN-1:0]    ram_wdata_o,
  // responses and stall requests
  output logic                fetch_done_o,
  output logic [`XLEN-1:0]    fetch_rdata_o,
  output logic                data_done_o,
  output logic [`XLEN-1:0]    data_rdata_o,
  output logic                fetch_wait_o,
  output logic                data_wait_o
);

  logic                fetch_pend_q;
  logic [`RAM_AW-1:0]  fetch_addr_q;
  logic                data_pend_q;
  logic                data_we_q;
  logic [`RAM_AW-1:0]  data_addr_q;
  logic [`XLEN-1:0]    data_wdata_q;
  logic                busy_q;                    // op in flight
  mem_pkg::requester_e owner_q;

  logic data_avail, fetch_avail;
  logic grant_data, grant_fetch;

  // ====================
  // grant, data first
  // ====================
  assign data_avail  = data_pend_q | data_req_i;  // held or fresh
  assign fetch_avail = fetch_pend_q | fetch_req_i;
  assign grant_data  = ~busy_q & data_avail;
  assign grant_fetch = ~busy_q & ~data_avail & fetch_avail;

  assign ram_start_o = grant_data | grant_fetch;
  assign ram_we_o    = grant_data & (data_pend_q ? data_we_q : data_we_i);
  assign ram_wdata_o = data_pend_q ? data_wdata_q : data_wdata_i;

  always_comb begin
    if (grant_data) begin
      ram_addr_o = data_pend_q ? data_addr_q : data_addr_i;
    end else begin
      ram_addr_o = fetch_pend_q ? fetch_addr_q : fetch_addr_i;
    end
  end

  // done goes back to whoever owns the ram
  assign fetch_done_o  = ram_done_i & (owner_q == mem_pkg::FETCH);
  assign data_done_o   = ram_done_i & (owner_q == mem_pkg::DATA);
  assign fetch_rdata_o = ram_rdata_i;
  assign data_rdata_o  = ram_rdata_i;

  // waiting from strobe through own done
  assign data_wait_o  = data_avail | (busy_q & (owner_q == mem_pkg::DATA));
  assign fetch_wait_o = fetch_avail | (busy_q & (owner_q == mem_pkg::FETCH));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fetch_pend_q <= 1'b0;
      data_pend_q  <= 1'b0;
      busy_q       <= 1'b0;
      owner_q      <= mem_pkg::FETCH;
    end else begin
      if (grant_data) data_pend_q <= 1'b0;
      else if (data_req_i) data_pend_q <= 1'b1;   // ram busy, keep it
      if (grant_fetch) fetch_pend_q <= 1'b0;
      else if (fetch_req_i) fetch_pend_q <= 1'b1;
      if (ram_start_o) begin
        busy_q  <= 1'b1;
        owner_q <= grant_data ? mem_pkg::DATA : mem_pkg::FETCH;
      end else if (ram_done_i) begin
        busy_q  <= 1'b0;
      end
    end
  end

  // request payload, captured only when nothing is held yet
  always_ff @(posedge clk) begin
    if (data_req_i && !data_pend_q) begin
      data_we_q    <= data_we_i;
      data_addr_q  <= data_addr_i;
      data_wdata_q <= data_wdata_i;
    end
    if (fetch_req_i && !fetch_pend_q) fetch_addr_q <= fetch_addr_i;
  end

endmodule

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none
`include "pipe_params.svh"

package mem_pkg;

  // owner of the shared ram
  typedef enum logic {
    FETCH = 1'b0,
    DATA  = 1'b1
  } requester_e;

  // one fetched word, seen as a full instruction or as two halves
  // half[0] is the low parcel, half[1] the high one
  typedef union packed {
    logic [`XLEN-1:0]                full;
    logic [1:0][`XLEN/2-1:0]         half;
  } instr_word_u;

  // rvc parcel unless the low two bits are 11
  function automatic logic is_compressed(input logic [`XLEN/2-1:0] parcel);
    return parcel[1:0] != 2'b11;
  endfunction

endpackage

`default_nettype wire

//--- source/pipe_ctrl_pkg.sv
`default_nettype none
`include "pipe_params.svh"

package pipe_ctrl_pkg;

  // stage index, also the bit position in a stage vector
  typedef enum logic [2:0] {
    PC     = 3'd0,
    PRE_IF = 3'd1,
    IF_ID  = 3'd2,
    ID_EX  = 3'd3,
    EX_MEM = 3'd4,
    MEM_WB = 3'd5
  } stage_e;

  typedef logic [`PIPE_STAGES-1:0] stage_vec_t; // shared by stall and flush

  // single stage bits
  localparam stage_vec_t S_PC     = stage_vec_t'(1) << PC;
  localparam stage_vec_t S_PRE_IF = stage_vec_t'(1) << PRE_IF;
  localparam stage_vec_t S_IF_ID  = stage_vec_t'(1) << IF_ID;
  localparam stage_vec_t S_ID_EX  = stage_vec_t'(1) << ID_EX;
  localparam stage_vec_t S_EX_MEM = stage_vec_t'(1) << EX_MEM;
  localparam stage_vec_t S_MEM_WB = stage_vec_t'(1) << MEM_WB;

  // ====================
  // hazard masks
  // ====================
  localparam stage_vec_t NO_STAGE         = '0;
  localparam stage_vec_t RESET_FLUSH      = S_PC | S_PRE_IF | S_IF_ID | S_ID_EX | S_EX_MEM;

  localparam stage_vec_t MEM_STALL        = S_PC | S_PRE_IF | S_IF_ID | S_ID_EX;
  localparam stage_vec_t MEM_FLUSH        = S_EX_MEM;     // bubble into ex_mem
  localparam stage_vec_t IF_STALL         = MEM_STALL;    // fetch wait freezes the same stages
  localparam stage_vec_t IF_FLUSH         = NO_STAGE;

  localparam stage_vec_t TRAP_FLUSH_STALL = S_PRE_IF;
  localparam stage_vec_t TRAP_FLUSH_FLUSH = S_PRE_IF | S_IF_ID | S_ID_EX;
  localparam stage_vec_t TRAP_STALL_STALL = S_PC | S_PRE_IF | S_IF_ID | S_ID_EX | S_EX_MEM | S_MEM_WB;
  localparam stage_vec_t TRAP_STALL_FLUSH = S_PRE_IF | S_IF_ID | S_ID_EX;

  localparam stage_vec_t JUMP_STALL       = S_PRE_IF;
  localparam stage_vec_t JUMP_FLUSH       = S_PRE_IF | S_IF_ID; // drop wrong-path fetches
  localparam stage_vec_t MULDIV_STALL     = S_PC | S_PRE_IF | S_IF_ID;
  localparam stage_vec_t MULDIV_FLUSH     = S_ID_EX;
  localparam stage_vec_t LOAD_USE_STALL   = S_PC | S_PRE_IF;
  localparam stage_vec_t LOAD_USE_FLUSH   = S_IF_ID;      // bubble behind the load
  localparam stage_vec_t COMPRESS_STALL   = S_PRE_IF;
  localparam stage_vec_t COMPRESS_FLUSH   = S_PRE_IF;

endpackage

`default_nettype wire

//--- source/pipe_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_params.svh"

module pipe_ctrl_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       fetch_req_i,
  input  wire [`RAM_AW-1:0]         fetch_addr_i,
  input  wire                       data_req_i,
  input  wire                       data_we_i,
  input  wire [`RAM_AW-1:0]         data_addr_i,
  input  wire [`XLEN-1:0]           data_wdata_i,
  input  wire                       next_stall_preif_i,
  input  wire                       load_use_i,
  input  wire                       jump_i,
  input  wire                       muldiv_i,
  input  wire                       trap_stall_i,
  input  wire                       trap_flush_i,
  output logic                      instr_valid_o,
  output logic [`XLEN-1:0]          instr_o,
  output logic                      data_valid_o,
  output logic [`XLEN-1:0]          data_rdata_o,
  output pipe_ctrl_pkg::stage_vec_t stall_o,
  output pipe_ctrl_pkg::stage_vec_t flush_o
);

  // arbiter <-> ram
  logic               ram_start, ram_we, ram_done;
  logic [`RAM_AW-1:0] ram_addr;
  logic [`XLEN-1:0]   ram_wdata, ram_rdata;
  // fetch return and stall requests
  logic               fetch_done, fetch_wait, data_wait, compress_stall;
  logic [`XLEN-1:0]   fetch_rdata;

  mem_arbiter u_arb (
    .clk, .rst,
    .fetch_req_i, .fetch_addr_i,
    .data_req_i, .data_we_i, .data_addr_i, .data_wdata_i,
    .ram_done_i    (ram_done),
    .ram_rdata_i   (ram_rdata),
    .ram_start_o   (ram_start),
    .ram_we_o      (ram_we),
    .ram_addr_o    (ram_addr),
    .ram_wdata_o   (ram_wdata),
    .fetch_done_o  (fetch_done),
    .fetch_rdata_o (fetch_rdata),
    .data_done_o   (data_valid_o),
    .data_rdata_o  (data_rdata_o),
    .fetch_wait_o  (fetch_wait),
    .data_wait_o   (data_wait)
  );

  shared_ram u_ram (
    .clk, .rst,
    .start_i (ram_start),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .done_o  (ram_done),
    .rdata_o (ram_rdata)
  );

  fetch_align u_align (
    .clk, .rst,
    .word_valid_i     (fetch_done),
    .word_i           (fetch_rdata),
    .instr_valid_o,
    .instr_o,
    .compress_stall_o (compress_stall)
  );

  pipeline_control u_pctl (
    .clk, .rst,
    .compress_stall_i (compress_stall),
    .next_stall_preif_i,
    .ram_stall_if_i   (fetch_wait),
    .ram_stall_mem_i  (data_wait),
    .load_use_i, .jump_i, .muldiv_i,
    .trap_stall_i, .trap_flush_i,
    .stall_o, .flush_o
  );

endmodule

`default_nettype wire

//--- source/pipeline_control.sv
`timescale 1ns/1ns
`default_nettype none

module pipeline_control (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       compress_stall_i,
  input  wire                       next_stall_preif_i,
  input  wire                       ram_stall_if_i,   // fetch wait
  input  wire                       ram_stall_mem_i,  // data wait
  input  wire                       load_use_i,
  input  wire                       jump_i,
  input  wire                       muldiv_i,
  input  wire                       trap_stall_i,
  input  wire                       trap_flush_i,
  output pipe_ctrl_pkg::stage_vec_t stall_o,
  output pipe_ctrl_pkg::stage_vec_t flush_o
);

  logic mem_stall_q;                               // data wait, one cycle late
  logic post_rst_q;                                // first cycle out of reset
  logic force_adv;

  // one cycle pulse once the data wait drops
  assign force_adv = mem_stall_q & ~ram_stall_mem_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mem_stall_q <= 1'b0;
      post_rst_q  <= 1'b1;
    end else begin
      mem_stall_q <= ram_stall_mem_i;
      post_rst_q  <= 1'b0;
    end
  end

  // ====================
  // fixed priority
  // ====================
  always_comb begin
    if (rst || post_rst_q) begin
      stall_o = pipe_ctrl_pkg::NO_STAGE;
      flush_o = pipe_ctrl_pkg::RESET_FLUSH;
    end else if (ram_stall_mem_i) begin
      stall_o = pipe_ctrl_pkg::MEM_STALL;
      flush_o = pipe_ctrl_pkg::MEM_FLUSH;
    end else if (next_stall_preif_i) begin
      // let the pipe move once after the memory stall
      stall_o = force_adv ? pipe_ctrl_pkg::NO_STAGE : pipe_ctrl_pkg::MEM_STALL;
      flush_o = pipe_ctrl_pkg::NO_STAGE;
    end else if (ram_stall_if_i) begin
      stall_o = pipe_ctrl_pkg::IF_STALL;
      flush_o = pipe_ctrl_pkg::IF_FLUSH;
    end else if (trap_flush_i) begin
      stall_o = pipe_ctrl_pkg::TRAP_FLUSH_STALL;
      flush_o = pipe_ctrl_pkg::TRAP_FLUSH_FLUSH;
    end else if (trap_stall_i) begin
      stall_o = pipe_ctrl_pkg::TRAP_STALL_STALL; // freeze everything
      flush_o = pipe_ctrl_pkg::TRAP_STALL_FLUSH;
    end else if (jump_i) begin
      stall_o = pipe_ctrl_pkg::JUMP_STALL;
      flush_o = pipe_ctrl_pkg::JUMP_FLUSH;
    end else if (muldiv_i) begin
      stall_o = pipe_ctrl_pkg::MULDIV_STALL;
      flush_o = pipe_ctrl_pkg::MULDIV_FLUSH;
    end else if (load_use_i) begin
      stall_o = pipe_ctrl_pkg::LOAD_USE_STALL;
      flush_o = pipe_ctrl_pkg::LOAD_USE_FLUSH;
    end else if (compress_stall_i) begin
      stall_o = pipe_ctrl_pkg::COMPRESS_STALL;
      flush_o = pipe_ctrl_pkg::COMPRESS_FLUSH;
    end else begin
      stall_o = pipe_ctrl_pkg::NO_STAGE;         // free running
      flush_o = pipe_ctrl_pkg::NO_STAGE;
    end
  end

endmodule

`default_nettype wire

//--- source/shared_ram.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_params.svh"

module shared_ram (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 start_i,
  input  wire                 we_i,
  input  wire [`RAM_AW-1:0]   addr_i,
  input  wire [`XLEN-1:0]     wdata_i,
  output logic                done_o,
  output logic [`XLEN-1:0]    rdata_o
);

  localparam int CW = $clog2(`RAM_LAT + 1);

  logic [`XLEN-1:0]   mem_q [2**`RAM_AW];
  logic               busy_q;
  logic [CW-1:0]      cnt_q;                     // cycles left until done
  logic               we_q;
  logic [`RAM_AW-1:0] addr_q;
  logic [`XLEN-1:0]   wdata_q;
  logic [`XLEN-1:0]   rdata_q;

  assign done_o  = busy_q & (cnt_q == '0);
  assign rdata_o = rdata_q;                      // held from start through done

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i && !busy_q) begin
      busy_q <= 1'b1;
      cnt_q  <= CW'(`RAM_LAT - 1);
    end else if (done_o) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q  <= cnt_q - 1'b1;
    end
  end

  // array and operation payload
  always_ff @(posedge clk) begin
    if (start_i && !busy_q) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      if (!we_i) rdata_q <= mem_q[addr_i];       // read at accept
    end
    if (done_o && we_q) mem_q[addr_q] <= wdata_q; // write lands with done
  end

endmodule

`default_nettype wire
